// ==== src/lpif_pkg.sv ====
/*
  LPIF-side definitions shared by the adapter and its testbench.
  Holds the link state encodings and the known stream ids.
*/

`default_nettype none

package lpif_pkg;

  //////////////////////////////
  // Link state, LPIF encodings
  //////////////////////////////
  typedef enum logic [3:0] {
    st_reset     = 4'h0,
    st_active    = 4'h1,
    st_linkerror = 4'ha
  } lsm_state_t;

  // Stream id carried with every LPIF word
  typedef logic [7:0] stream_t;

  localparam stream_t mem_cache_stream_id = 8'h1;
  localparam stream_t io_stream_id        = 8'h2;
  localparam stream_t arb_mux_stream_id   = 8'h3;

endpackage

`default_nettype wire

// ==== src/aib_pkg.sv ====
/*
  Flit header layout on the AIB lane bus.
  The header sits in the top hdr_width bits of a lane word, data in the low bits.
*/

`default_nettype none

package aib_pkg;

  localparam int hdr_width = 10;

  // Bit positions inside the header
  localparam int hdr_valid_bit  = 9; // Lane word holds a flit
  localparam int hdr_credit_bit = 8; // One returned credit
  localparam int hdr_stream_lsb = 0; // 8-bit stream field

  typedef logic [hdr_width-1:0] lane_hdr_t;

endpackage

`default_nettype wire

// ==== src/lpif_lsm.sv ====
/*
  Link state machine. Moves between Reset, Active and LinkError
  from the LPIF state request and the PHY readiness inputs.
*/

`timescale 1ns/1ps
`default_nettype none

module lpif_lsm
(
  input  logic                 lclk,
  input  logic                 reset,
  input  logic [3:0]           lp_state_req,
  input  logic                 lp_linkerror,
  input  logic                 fs_mac_rdy,
  input  logic                 align_done,
  output lpif_pkg::lsm_state_t pl_state_sts,
  output logic                 link_active
);

  lpif_pkg::lsm_state_t state;
  lpif_pkg::lsm_state_t state_nxt;

  logic req_active;
  logic req_reset;
  logic phy_ready;

  assign req_active = (lp_state_req == lpif_pkg::st_active);
  assign req_reset  = (lp_state_req == lpif_pkg::st_reset);
  assign phy_ready  = fs_mac_rdy & align_done; // Far side up and lanes aligned

  //////////////////////////////
  // Next state
  //////////////////////////////
  always_comb
  begin
    state_nxt = state;
    case (state)
      lpif_pkg::st_reset:
      begin
        if (req_active && phy_ready)
          state_nxt = lpif_pkg::st_active;
      end
      lpif_pkg::st_active:
      begin
        // Far side dropping out counts as a link error
        if (lp_linkerror || !fs_mac_rdy)
          state_nxt = lpif_pkg::st_linkerror;
      end
      lpif_pkg::st_linkerror:
      begin
        if (req_reset && !lp_linkerror)
          state_nxt = lpif_pkg::st_reset;
      end
      default:
        state_nxt = lpif_pkg::st_reset;
    endcase
  end

  always_ff @(posedge lclk)
  begin
    if (reset)
      state <= lpif_pkg::st_reset;
    else
      state <= state_nxt;
  end

  assign pl_state_sts = state;
  assign link_active  = (state == lpif_pkg::st_active); // Gates the framer

endmodule

`default_nettype wire

// ==== src/lpif_tx_framer.sv ====
/*
  Downstream framer. Accepts LPIF words while it holds send credits
  and emits one registered lane word per cycle on data_in_f, with a
  header carrying flit-valid, stream id and one returned credit.
*/

`timescale 1ns/1ps
`default_nettype none

module lpif_tx_framer #(
  parameter int data_bytes    = 4,
  parameter int aib_lanes     = 2,
  parameter int bits_per_lane = 40,
  parameter int rx_fifo_depth = 8
)
(
  input  logic                               lclk,
  input  logic                               reset,
  input  logic                               link_active,
  input  logic                               lp_irdy,
  input  logic                               lp_valid,
  input  logic [data_bytes*8-1:0]            lp_data,
  input  lpif_pkg::stream_t                  lp_stream,
  input  logic                               credit_rcvd,
  input  logic                               rd_pop,
  output logic                               pl_trdy,
  output logic [aib_lanes*bits_per_lane-1:0] data_in_f
);

  localparam int lane_width = aib_lanes * bits_per_lane;
  localparam int cred_width = $clog2(rx_fifo_depth + 1);

  logic [cred_width-1:0]   credits;     // Free entries at the far receive buffer
  logic                    send;

  logic                    tx_valid_q;
  logic                    tx_credit_q; // Pending credit return
  lpif_pkg::stream_t       tx_stream_q;
  logic [data_bytes*8-1:0] tx_data_q;
  aib_pkg::lane_hdr_t      tx_hdr;

  assign pl_trdy = link_active && (credits != '0);
  assign send    = lp_irdy & lp_valid & pl_trdy;

  //////////////////////////////
  // Send credits
  //////////////////////////////
  always_ff @(posedge lclk)
  begin
    if (reset)
      credits <= cred_width'(rx_fifo_depth);
    else
    begin
      case ({send, credit_rcvd})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits; // None, or one spent and one back
      endcase
    end
  end

  // Header flags
  always_ff @(posedge lclk)
  begin
    if (reset)
    begin
      tx_valid_q  <= 1'b0;
      tx_credit_q <= 1'b0;
    end
    else
    begin
      tx_valid_q  <= send;
      tx_credit_q <= rd_pop; // Each pop rides out on the next word
    end
  end

  // Payload holds its last value between flits
  always_ff @(posedge lclk)
  begin
    if (send)
    begin
      tx_stream_q <= lp_stream;
      tx_data_q   <= lp_data;
    end
  end

  //////////////////////////////
  // Lane word assembly
  //////////////////////////////
  always_comb
  begin
    tx_hdr                                 = '0;
    tx_hdr[aib_pkg::hdr_valid_bit]         = tx_valid_q;
    tx_hdr[aib_pkg::hdr_credit_bit]        = tx_credit_q;
    tx_hdr[aib_pkg::hdr_stream_lsb +: $bits(lpif_pkg::stream_t)] = tx_stream_q;

    data_in_f                                   = '0;
    data_in_f[lane_width-1 -: aib_pkg::hdr_width] = tx_hdr;
    data_in_f[data_bytes*8-1:0]                 = tx_data_q;
  end

endmodule

`default_nettype wire

// ==== src/lpif_rx_fifo.sv ====
/*
  Receive buffer. Registers the lane word from dout, or from data_in_f
  in loopback, splits off the header and stores valid flits in a
  circular FIFO. Credit bits in received headers pulse credit_rcvd.
*/

`timescale 1ns/1ps
`default_nettype none

module lpif_rx_fifo #(
  parameter int data_bytes    = 4,
  parameter int aib_lanes     = 2,
  parameter int bits_per_lane = 40,
  parameter int rx_fifo_depth = 8
)
(
  input  logic                               lclk,
  input  logic                               reset,
  input  logic                               lpbk_en,
  input  logic [aib_lanes*bits_per_lane-1:0] data_in_f,
  input  logic [aib_lanes*bits_per_lane-1:0] dout,
  input  logic                               rd_pop,
  output logic                               rd_valid,
  output lpif_pkg::stream_t                  rd_stream,
  output logic [data_bytes*8-1:0]            rd_data,
  output logic                               credit_rcvd
);

  localparam int lane_width = aib_lanes * bits_per_lane;
  localparam int ptr_width  = (rx_fifo_depth > 1) ? $clog2(rx_fifo_depth) : 1;
  localparam int cnt_width  = $clog2(rx_fifo_depth + 1);

  logic [lane_width-1:0]   lane_sel;
  aib_pkg::lane_hdr_t      rx_hdr_q;
  logic [data_bytes*8-1:0] rx_data_q;
  logic                    wr_en;

  lpif_pkg::stream_t       mem_stream [rx_fifo_depth];
  logic [data_bytes*8-1:0] mem_data   [rx_fifo_depth];
  logic [ptr_width-1:0]    wr_ptr;
  logic [ptr_width-1:0]    rd_ptr;
  logic [cnt_width-1:0]    count;

  assign lane_sel = lpbk_en ? data_in_f : dout; // Loopback select

  //////////////////////////////
  // Input register
  //////////////////////////////
  always_ff @(posedge lclk)
  begin
    if (reset)
      rx_hdr_q <= '0;
    else
      rx_hdr_q <= lane_sel[lane_width-1 -: aib_pkg::hdr_width];
  end

  always_ff @(posedge lclk)
  begin
    rx_data_q <= lane_sel[data_bytes*8-1:0];
  end

  assign wr_en       = rx_hdr_q[aib_pkg::hdr_valid_bit];
  assign credit_rcvd = rx_hdr_q[aib_pkg::hdr_credit_bit]; // One cycle per header

  //////////////////////////////
  // Flit storage
  //////////////////////////////
  // Sender credits keep a write away from a full buffer
  always_ff @(posedge lclk)
  begin
    if (wr_en)
    begin
      mem_stream[wr_ptr] <= rx_hdr_q[aib_pkg::hdr_stream_lsb +: $bits(lpif_pkg::stream_t)];
      mem_data[wr_ptr]   <= rx_data_q;
    end
  end

  always_ff @(posedge lclk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= (wr_ptr == ptr_width'(rx_fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (rd_pop)
        rd_ptr <= (rd_ptr == ptr_width'(rx_fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      case ({wr_en, rd_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head entry
  assign rd_valid  = (count != '0);
  assign rd_stream = mem_stream[rd_ptr];
  assign rd_data   = mem_data[rd_ptr];

endmodule

`default_nettype wire

// ==== src/lpif_rx_deliver.sv ====
/*
  Upstream delivery stage. Pops the receive FIFO head every cycle one is
  present and registers it onto the pl_ ports. Flits with an unknown
  stream id are dropped and flagged on pl_error for one cycle.
*/

`timescale 1ns/1ps
`default_nettype none

module lpif_rx_deliver #(
  parameter int data_bytes = 4
)
(
  input  logic                    lclk,
  input  logic                    reset,
  input  logic                    rd_valid,
  input  lpif_pkg::stream_t       rd_stream,
  input  logic [data_bytes*8-1:0] rd_data,
  output logic                    rd_pop,
  output logic                    pl_valid,
  output logic                    pl_error,
  output lpif_pkg::stream_t       pl_stream,
  output logic [data_bytes*8-1:0] pl_data
);

  logic known;

  // No back-pressure upstream, so drain whenever possible
  assign rd_pop = rd_valid;

  assign known = (rd_stream == lpif_pkg::mem_cache_stream_id) ||
                 (rd_stream == lpif_pkg::io_stream_id)        ||
                 (rd_stream == lpif_pkg::arb_mux_stream_id);

  always_ff @(posedge lclk)
  begin
    if (reset)
    begin
      pl_valid <= 1'b0;
      pl_error <= 1'b0;
    end
    else
    begin
      pl_valid <= rd_pop & known;
      pl_error <= rd_pop & ~known; // Dropped flit
    end
  end

  always_ff @(posedge lclk)
  begin
    if (rd_pop && known)
    begin
      pl_stream <= rd_stream;
      pl_data   <= rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== src/lpif_adapter.sv ====
/*
  LPIF to AIB link adapter, top level. Wires the link state machine,
  the downstream framer, the receive FIFO and the delivery stage,
  and passes the width and depth parameters down.
*/

`timescale 1ns/1ps
`default_nettype none

module lpif_adapter #(
  parameter int data_bytes    = 4,
  parameter int aib_lanes     = 2,
  parameter int bits_per_lane = 40,
  parameter int rx_fifo_depth = 8
)
(
  input  logic                               lclk,
  input  logic                               reset,

  // LPIF
  input  logic                               lp_irdy,
  input  logic                               lp_valid,
  input  logic [data_bytes*8-1:0]            lp_data,
  input  lpif_pkg::stream_t                  lp_stream,
  input  logic [3:0]                         lp_state_req,
  input  logic                               lp_linkerror,
  output logic                               pl_trdy,
  output logic                               pl_valid,
  output logic [data_bytes*8-1:0]            pl_data,
  output lpif_pkg::stream_t                  pl_stream,
  output logic                               pl_error,
  output lpif_pkg::lsm_state_t               pl_state_sts,
  output logic                               pl_lnk_up,

  // AIB
  output logic [aib_lanes*bits_per_lane-1:0] data_in_f,
  input  logic [aib_lanes*bits_per_lane-1:0] dout,
  input  logic                               fs_mac_rdy,
  input  logic                               align_done,

  input  logic                               lpbk_en
);

  logic                    link_active;
  logic                    credit_rcvd;
  logic                    rd_pop;
  logic                    rd_valid;
  lpif_pkg::stream_t       rd_stream;
  logic [data_bytes*8-1:0] rd_data;

  assign pl_lnk_up = link_active;

  //////////////////////////////
  // Link state machine
  //////////////////////////////
  lpif_lsm lpif_lsm_i (
    .lclk         (lclk),
    .reset        (reset),
    .lp_state_req (lp_state_req),
    .lp_linkerror (lp_linkerror),
    .fs_mac_rdy   (fs_mac_rdy),
    .align_done   (align_done),
    .pl_state_sts (pl_state_sts),
    .link_active  (link_active)
  );

  //////////////////////////////
  // Downstream
  //////////////////////////////
  lpif_tx_framer #(
    .data_bytes    (data_bytes),
    .aib_lanes     (aib_lanes),
    .bits_per_lane (bits_per_lane),
    .rx_fifo_depth (rx_fifo_depth)  // Far buffer size sets starting credits
  ) lpif_tx_framer_i (
    .lclk        (lclk),
    .reset       (reset),
    .link_active (link_active),
    .lp_irdy     (lp_irdy),
    .lp_valid    (lp_valid),
    .lp_data     (lp_data),
    .lp_stream   (lp_stream),
    .credit_rcvd (credit_rcvd),
    .rd_pop      (rd_pop),
    .pl_trdy     (pl_trdy),
    .data_in_f   (data_in_f)
  );

  //////////////////////////////
  // Upstream
  //////////////////////////////
  lpif_rx_fifo #(
    .data_bytes    (data_bytes),
    .aib_lanes     (aib_lanes),
    .bits_per_lane (bits_per_lane),
    .rx_fifo_depth (rx_fifo_depth)
  ) lpif_rx_fifo_i (
    .lclk        (lclk),
    .reset       (reset),
    .lpbk_en     (lpbk_en),
    .data_in_f   (data_in_f),
    .dout        (dout),
    .rd_pop      (rd_pop),
    .rd_valid    (rd_valid),
    .rd_stream   (rd_stream),
    .rd_data     (rd_data),
    .credit_rcvd (credit_rcvd)
  );

  lpif_rx_deliver #(
    .data_bytes (data_bytes)
  ) lpif_rx_deliver_i (
    .lclk      (lclk),
    .reset     (reset),
    .rd_valid  (rd_valid),
    .rd_stream (rd_stream),
    .rd_data   (rd_data),
    .rd_pop    (rd_pop),
    .pl_valid  (pl_valid),
    .pl_error  (pl_error),
    .pl_stream (pl_stream),
    .pl_data   (pl_data)
  );

endmodule

`default_nettype wire

// ==== bench/lpif_adapter_sva.sv ====
/*
  Concurrent assertions for the adapter top level, attached with bind.
  Follows the send credits from the lane headers to check the LPIF
  handshake, and ties each upstream flit to the lane word it came from.
*/

`timescale 1ns/1ps
`default_nettype none

module lpif_adapter_sva #(
  parameter int aib_lanes     = 2,
  parameter int bits_per_lane = 40,
  parameter int rx_fifo_depth = 8
)
(
  input  logic                               lclk,
  input  logic                               reset,
  input  logic                               pl_trdy,
  input  logic                               pl_valid,
  input  lpif_pkg::stream_t                  pl_stream,
  input  lpif_pkg::lsm_state_t               pl_state_sts,
  input  logic [aib_lanes*bits_per_lane-1:0] data_in_f,
  input  logic [aib_lanes*bits_per_lane-1:0] dout,
  input  logic                               lpbk_en
);

  localparam int lane_width = aib_lanes * bits_per_lane;
  localparam int hdr_base   = lane_width - aib_pkg::hdr_width;
  localparam int rx_latency = 3; // Received lane word to pl_valid

  logic [lane_width-1:0] lane_rx;
  logic                  flit_out;
  logic                  rx_valid;
  lpif_pkg::stream_t     rx_stream;
  logic                  rx_credit;
  logic                  rx_credit_q;
  logic                  rx_credit_qq;
  int                    credits_prev; // Framer credits one cycle back
  int                    credits_now;

  assign flit_out  = data_in_f[hdr_base + aib_pkg::hdr_valid_bit]; // Flit-valid bit
  assign lane_rx   = lpbk_en ? data_in_f : dout;
  assign rx_valid  = lane_rx[hdr_base + aib_pkg::hdr_valid_bit];
  assign rx_credit = lane_rx[hdr_base + aib_pkg::hdr_credit_bit];
  assign rx_stream = lane_rx[hdr_base + aib_pkg::hdr_stream_lsb +:
                             $bits(lpif_pkg::stream_t)];

  function automatic logic known_id(input lpif_pkg::stream_t s);
    return (s == lpif_pkg::mem_cache_stream_id) || (s == lpif_pkg::io_stream_id) ||
           (s == lpif_pkg::arb_mux_stream_id);
  endfunction

  //////////////////////////////
  // Send credit model
  //////////////////////////////
  // A credit bit reaches the framer count two edges after it is on the lane
  always_ff @(posedge lclk)
  begin
    if (reset)
    begin
      rx_credit_q  <= 1'b0;
      rx_credit_qq <= 1'b0;
      credits_prev <= rx_fifo_depth;
    end
    else
    begin
      rx_credit_q  <= rx_credit;
      rx_credit_qq <= rx_credit_q;
      credits_prev <= credits_now;
    end
  end

  // Each flit on the lane bus was paid for in the cycle before
  assign credits_now = credits_prev - int'(flit_out) + int'(rx_credit_qq);

  //////////////////////////////
  // Properties
  //////////////////////////////
  trdy_only_active: assert property (@(posedge lclk) disable iff (reset)
    pl_trdy == ((pl_state_sts == lpif_pkg::st_active) && (credits_now != 0)))
    else $error("pl_trdy does not follow the link state and send credits");

  // Each upstream flit is the lane word received three cycles before
  known_stream_only: assert property (@(posedge lclk) disable iff (reset)
    pl_valid |-> (known_id(pl_stream) && $past(rx_valid, rx_latency) &&
                  (pl_stream == $past(rx_stream, rx_latency))))
    else $error("pl_valid with an unknown or mismatched stream id");

  flit_needs_credit: assert property (@(posedge lclk) disable iff (reset)
    flit_out |-> (credits_prev != 0))
    else $error("flit sent on data_in_f without a send credit");

endmodule

bind lpif_adapter lpif_adapter_sva #(
  .aib_lanes     (aib_lanes),
  .bits_per_lane (bits_per_lane),
  .rx_fifo_depth (rx_fifo_depth)
) lpif_adapter_sva_i (
  .lclk         (lclk),
  .reset        (reset),
  .pl_trdy      (pl_trdy),
  .pl_valid     (pl_valid),
  .pl_stream    (pl_stream),
  .pl_state_sts (pl_state_sts),
  .data_in_f    (data_in_f),
  .dout         (dout),
  .lpbk_en      (lpbk_en)
);

`default_nettype wire

// ==== bench/lpif_adapter_tb.sv ====
/*
  Testbench for the LPIF to AIB adapter. Runs the link states, random
  traffic in loopback, the send-credit limit and flits from a far-side
  credit model on dout, all checked against a scoreboard.
*/

`timescale 1ns/1ps
`default_nettype none

module lpif_adapter_tb;

  localparam int data_bytes    = 4;
  localparam int aib_lanes     = 2;
  localparam int bits_per_lane = 40;
  localparam int rx_fifo_depth = 8;

  localparam int data_w     = data_bytes * 8;
  localparam int lane_width = aib_lanes * bits_per_lane;
  localparam int hdr_base   = lane_width - aib_pkg::hdr_width;
  localparam int valid_pos  = hdr_base + aib_pkg::hdr_valid_bit;
  localparam int credit_pos = hdr_base + aib_pkg::hdr_credit_bit;
  localparam int stream_pos = hdr_base + aib_pkg::hdr_stream_lsb;

  localparam int clk_period   = 4;
  localparam int lpbk_cycles  = 300;
  localparam int ext_cycles   = 200;
  localparam int max_trans    = lpbk_cycles + ext_cycles + 64;
  localparam int loop_latency = 4; // Accept to pl_valid over the lane bus
  localparam int ext_latency  = 3; // dout word to pl_valid

  typedef struct packed {
    lpif_pkg::stream_t stream;
    logic [data_w-1:0] data;
    logic [31:0]       due;    // Cycle the flit shows upstream
  } flit_t;

  logic                 lclk;
  logic                 reset;
  logic                 lp_irdy;
  logic                 lp_valid;
  logic [data_w-1:0]    lp_data;
  lpif_pkg::stream_t    lp_stream;
  logic [3:0]           lp_state_req;
  logic                 lp_linkerror;
  logic                 fs_mac_rdy;
  logic                 align_done;
  logic                 lpbk_en;
  logic [lane_width-1:0] dout;

  logic                 pl_trdy;
  logic                 pl_valid;
  logic                 pl_error;
  logic                 pl_lnk_up;
  logic [data_w-1:0]    pl_data;
  lpif_pkg::stream_t    pl_stream;
  lpif_pkg::lsm_state_t pl_state_sts;
  logic [lane_width-1:0] data_in_f;

  flit_t       tx_q[$]; // Words expected on data_in_f
  flit_t       rx_q[$]; // Flits expected upstream
  int unsigned cyc;
  int unsigned mismatches;
  int unsigned failures;
  int unsigned accepted;
  int unsigned credit_bits;
  int unsigned delivered;
  int unsigned dropped;
  int unsigned far_credits; // Far side's credits toward our buffer

  lpif_adapter #(
    .data_bytes    (data_bytes),
    .aib_lanes     (aib_lanes),
    .bits_per_lane (bits_per_lane),
    .rx_fifo_depth (rx_fifo_depth)
  ) DUT (
    .lclk         (lclk),
    .reset        (reset),
    .lp_irdy      (lp_irdy),
    .lp_valid     (lp_valid),
    .lp_data      (lp_data),
    .lp_stream    (lp_stream),
    .lp_state_req (lp_state_req),
    .lp_linkerror (lp_linkerror),
    .pl_trdy      (pl_trdy),
    .pl_valid     (pl_valid),
    .pl_data      (pl_data),
    .pl_stream    (pl_stream),
    .pl_error     (pl_error),
    .pl_state_sts (pl_state_sts),
    .pl_lnk_up    (pl_lnk_up),
    .data_in_f    (data_in_f),
    .dout         (dout),
    .fs_mac_rdy   (fs_mac_rdy),
    .align_done   (align_done),
    .lpbk_en      (lpbk_en)
  );

  initial
  begin
    lclk = 1'b0;
    forever #(clk_period / 2) lclk = ~lclk;
  end

  always @(posedge lclk)
  begin
    if (reset)
      cyc <= 0;
    else
      cyc <= cyc + 1;
  end

  initial
  begin
    #(max_trans * 20 * clk_period);
    $display("timeout: run did not finish within %0d cycles", max_trans * 20);
    $display("RESULT: FAIL");
    $finish;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////
  function automatic logic [lane_width-1:0] lane_word(input logic valid, input logic credit,
                                                      input lpif_pkg::stream_t s,
                                                      input logic [data_w-1:0] d);
    logic [lane_width-1:0] w;
    w                  = '0;
    w[valid_pos]       = valid;
    w[credit_pos]      = credit;
    w[stream_pos +: 8] = s;
    w[data_w-1:0]      = d;
    return w;
  endfunction

  function automatic logic known_stream(input lpif_pkg::stream_t s);
    return (s == lpif_pkg::mem_cache_stream_id) || (s == lpif_pkg::io_stream_id) ||
           (s == lpif_pkg::arb_mux_stream_id);
  endfunction

  // Mostly known ids, one in four unknown
  function automatic lpif_pkg::stream_t pick_stream();
    int unsigned sel;
    sel = $urandom % 8;
    case (sel)
      0, 1:    return lpif_pkg::mem_cache_stream_id;
      2, 3:    return lpif_pkg::io_stream_id;
      4, 5:    return lpif_pkg::arb_mux_stream_id;
      default: return lpif_pkg::stream_t'(8'h40 + sel);
    endcase
  endfunction

  task automatic log_mismatch(input string msg);
    mismatches++;
    $display("mismatch at %0t: %s", $time, msg);
  endtask

  task automatic flag_failure(input string msg);
    failures++;
    $display("error at %0t: %s", $time, msg);
  endtask

  task automatic next_cycle();
    @(negedge lclk);
  endtask

  task automatic verify_reset_outputs();
    if (pl_trdy !== 1'b0 || pl_valid !== 1'b0 || pl_error !== 1'b0 || pl_lnk_up !== 1'b0)
      log_mismatch($sformatf("reset outputs trdy %b valid %b error %b lnk_up %b",
                             pl_trdy, pl_valid, pl_error, pl_lnk_up));
    if (data_in_f[valid_pos] !== 1'b0 || data_in_f[credit_pos] !== 1'b0)
      log_mismatch("lane header flags not low after reset");
    if (pl_state_sts !== lpif_pkg::st_reset)
      log_mismatch($sformatf("pl_state_sts %0h after reset", pl_state_sts));
  endtask

  task automatic expect_state(input lpif_pkg::lsm_state_t exp);
    if (pl_state_sts !== exp)
      log_mismatch($sformatf("pl_state_sts %0h, expected %0h", pl_state_sts, exp));
    if (pl_lnk_up !== (exp == lpif_pkg::st_active))
      log_mismatch($sformatf("pl_lnk_up %b in state %0h", pl_lnk_up, exp));
    if (exp != lpif_pkg::st_active && pl_trdy !== 1'b0)
      log_mismatch("pl_trdy high outside the active state");
  endtask

  // Called right after a falling edge; the word is taken on the next rise
  task automatic drive_lpif(input logic irdy, input logic valid, input logic looped);
    flit_t f;
    lp_irdy   = irdy;
    lp_valid  = valid;
    lp_data   = $urandom;
    lp_stream = pick_stream();
    if (irdy && valid && pl_trdy === 1'b1)
    begin
      f.stream = lp_stream;
      f.data   = lp_data;
      f.due    = cyc + loop_latency;
      tx_q.push_back(f);
      if (looped)
        rx_q.push_back(f);
      accepted++;
    end
  endtask

  // Far side: spends credits on dout flits, regains them from data_in_f
  task automatic far_side_cycle(input logic active);
    flit_t f;
    if (data_in_f[credit_pos] === 1'b1)
      far_credits++;
    if (far_credits > rx_fifo_depth)
      flag_failure("far side got back more credits than the receive buffer holds");
    if (active && far_credits != 0 && ($urandom % 4) != 0)
    begin
      f.stream = pick_stream();
      f.data   = $urandom;
      f.due    = cyc + ext_latency;
      dout     = lane_word(1'b1, 1'b0, f.stream, f.data);
      rx_q.push_back(f);
      far_credits--;
    end
    else
      dout = '0;
  endtask

  task automatic drain(input logic far_side);
    while (rx_q.size() != 0 || tx_q.size() != 0)
    begin
      next_cycle();
      if (far_side)
        far_side_cycle(1'b0);
    end
    repeat (4)
    begin
      next_cycle();
      if (far_side)
        far_side_cycle(1'b0); // Late credit bits
    end
  endtask

  //////////////////////////////
  // Scoreboard
  //////////////////////////////
  task automatic watch_lane_bus();
    flit_t                 e;
    logic [lane_width-1:0] w;
    if (data_in_f[credit_pos] === 1'b1)
      credit_bits++;
    if (data_in_f[valid_pos] === 1'b1)
    begin
      if (tx_q.size() == 0)
        flag_failure("flit on data_in_f with no accepted LPIF word");
      else
      begin
        e             = tx_q.pop_front();
        w             = data_in_f;
        w[credit_pos] = 1'b0;
        if (w !== lane_word(1'b1, 1'b0, e.stream, e.data))
          log_mismatch($sformatf("data_in_f %h, expected stream %h data %h",
                                 data_in_f, e.stream, e.data));
      end
    end
  endtask

  task automatic watch_upstream();
    flit_t e;
    if (pl_valid === 1'b1 && pl_error === 1'b1)
      flag_failure("pl_valid and pl_error high in the same cycle");
    else if (pl_valid === 1'b1 || pl_error === 1'b1)
    begin
      if (rx_q.size() == 0)
        flag_failure("upstream output with no flit outstanding");
      else
      begin
        e = rx_q.pop_front();
        if (cyc != e.due)
          log_mismatch($sformatf("flit arrived in cycle %0d, expected %0d", cyc, e.due));
        if (known_stream(e.stream))
        begin
          delivered++;
          if (pl_valid !== 1'b1 || pl_stream !== e.stream || pl_data !== e.data)
            log_mismatch($sformatf("pl_ stream %h data %h, expected %h %h",
                                   pl_stream, pl_data, e.stream, e.data));
        end
        else
        begin
          dropped++;
          if (pl_error !== 1'b1)
            log_mismatch($sformatf("unknown stream %h not flagged on pl_error", e.stream));
        end
      end
    end
  endtask

  always @(negedge lclk)
  begin
    if (!reset)
    begin
      watch_lane_bus();
      watch_upstream();
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial
  begin
    int unsigned returned;
    reset        = 1'b1;
    lp_irdy      = 1'b0;
    lp_valid     = 1'b0;
    lp_data      = '0;
    lp_stream    = '0;
    lp_state_req = lpif_pkg::st_reset;
    lp_linkerror = 1'b0;
    fs_mac_rdy   = 1'b0;
    align_done   = 1'b0;
    lpbk_en      = 1'b0;
    dout         = '0;
    mismatches   = 0;
    failures     = 0;
    accepted     = 0;
    credit_bits  = 0;
    delivered    = 0;
    dropped      = 0;
    far_credits  = rx_fifo_depth;
    void'($urandom(32'h57f1_a06a));

    repeat (16)
    begin
      next_cycle();
      verify_reset_outputs();
    end
    reset = 1'b0;
    repeat (2)
    begin
      next_cycle();
      verify_reset_outputs();
    end

    // Link states, each change seen one cycle after its cause
    lp_state_req = lpif_pkg::st_active;
    fs_mac_rdy   = 1'b1;
    next_cycle();
    expect_state(lpif_pkg::st_reset); // Lanes not aligned yet
    align_done = 1'b1;
    next_cycle();
    expect_state(lpif_pkg::st_active);
    if (pl_trdy !== 1'b1)
      log_mismatch("pl_trdy low in the active state with credits");
    lp_linkerror = 1'b1;
    next_cycle();
    expect_state(lpif_pkg::st_linkerror);
    lp_state_req = lpif_pkg::st_reset;
    next_cycle();
    expect_state(lpif_pkg::st_linkerror);
    lp_linkerror = 1'b0;
    next_cycle();
    expect_state(lpif_pkg::st_reset);
    lp_state_req = lpif_pkg::st_active;
    next_cycle();
    expect_state(lpif_pkg::st_active);
    fs_mac_rdy = 1'b0;                // Far side drops out
    next_cycle();
    expect_state(lpif_pkg::st_linkerror);
    fs_mac_rdy   = 1'b1;
    lp_state_req = lpif_pkg::st_reset;
    next_cycle();
    expect_state(lpif_pkg::st_reset);
    lp_state_req = lpif_pkg::st_active;
    next_cycle();
    expect_state(lpif_pkg::st_active);

    // Loopback traffic
    lpbk_en = 1'b1;
    repeat (lpbk_cycles)
    begin
      next_cycle();
      drive_lpif(($urandom % 2) == 1, ($urandom % 4) != 0, 1'b1);
    end
    next_cycle();
    drive_lpif(1'b0, 1'b0, 1'b0);
    drain(1'b0);

    // Credit limit with a silent far side
    lpbk_en  = 1'b0;
    accepted = 0;
    repeat (16)
    begin
      next_cycle();
      drive_lpif(1'b1, 1'b1, 1'b0);
    end
    if (accepted != rx_fifo_depth)
      log_mismatch($sformatf("%0d words accepted on full credits", accepted));
    if (pl_trdy !== 1'b0)
      log_mismatch("pl_trdy high with no send credits left");
    for (returned = 1; returned <= 3; returned++)
    begin
      next_cycle();
      dout = lane_word(1'b0, 1'b1, '0, '0);
      drive_lpif(1'b1, 1'b1, 1'b0);
      next_cycle();
      dout = '0;
      drive_lpif(1'b1, 1'b1, 1'b0);
      repeat (5)
      begin
        next_cycle();
        drive_lpif(1'b1, 1'b1, 1'b0);
      end
      if (accepted != rx_fifo_depth + returned)
        log_mismatch($sformatf("%0d words accepted after %0d returned credits",
                               accepted, returned));
    end
    next_cycle();
    drive_lpif(1'b0, 1'b0, 1'b0);

    // External receive from the far side
    far_credits = rx_fifo_depth;
    repeat (ext_cycles)
    begin
      next_cycle();
      far_side_cycle(1'b1);
    end
    drain(1'b1);

    if (far_credits != rx_fifo_depth)
      log_mismatch($sformatf("far side ends with %0d credits", far_credits));
    if (credit_bits != delivered + dropped)
      log_mismatch($sformatf("%0d credit bits on data_in_f for %0d popped flits",
                             credit_bits, delivered + dropped));
    if (delivered == 0 || dropped == 0)
      flag_failure("traffic did not reach both delivered and dropped flits");

    $display("summary: %0d delivered, %0d dropped, %0d mismatches, %0d other errors",
             delivered, dropped, mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== lpif_adapter.f ====
src/lpif_pkg.sv
src/aib_pkg.sv
src/lpif_lsm.sv
src/lpif_tx_framer.sv
src/lpif_rx_fifo.sv
src/lpif_rx_deliver.sv
src/lpif_adapter.sv
bench/lpif_adapter_sva.sv
bench/lpif_adapter_tb.sv

// ==== Makefile ====
# Verilator build and run for the LPIF to AIB adapter

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = lpif_adapter_tb
FILELIST  = lpif_adapter.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
